// File: source/fpRoundPkg.sv
package fpRoundPkg;

	// ========================================================================
	// format widths
	// ========================================================================
	localparam int laneCount = 4;		// lanes per vector
	localparam int fpWidth   = 32;		// rounded single-precision word
	localparam int expWidth  = 8;		// biased exponent
	localparam int fracWidth = 23;		// stored fraction, hidden bit not counted
	localparam int wideWidth = 35;		// sign + exp + 24-bit significand + round + sticky

	// plain vectors with a meaning
	typedef logic [fpWidth-1:0]   fpWord;	// final IEEE 754 word
	typedef logic [wideWidth-1:0] fpWide;	// intermediate value, see layout below
	typedef logic [2:0]           roundMode;

	// fpWide layout, msb first:
	//   [34]    sign
	//   [33:26] exponent
	//   [25:2]  significand with visible leading bit, [2] is the kept lsb
	//   [1]     round bit
	//   [0]     sticky bit

	// ========================================================================
	// rounding mode codes
	// ========================================================================
	localparam roundMode rmNearestEven = 3'd0;	// ties to even
	localparam roundMode rmZero        = 3'd1;	// truncate
	localparam roundMode rmPlusInf     = 3'd2;	// toward +inf
	localparam roundMode rmMinusInf    = 3'd3;	// toward -inf
	localparam roundMode rmAway        = 3'd4;	// up in magnitude on any lost bit
	localparam roundMode rmDynamic     = 3'd7;	// take the mode register instead
	// 5 and 6 are reserved, the lane leaves the value unrounded

	// ========================================================================
	// bundles
	// ========================================================================
	typedef struct packed {
		fpWide    value;	// intermediate value to round
		roundMode mode;		// already resolved, never rmDynamic
	} laneReq;

	typedef struct packed {
		fpWord result;		// rounded word
		logic  inexact;		// some bit was lost
		logic  overflow;	// rounding carried into an all-ones exponent
	} laneRes;

	typedef struct packed {
		logic inexact;
		logic overflow;
	} fpFlags;

endpackage

// File: source/fpRoundIssue.sv
module fpRoundIssue (
	input  logic                                           clk,
	input  logic                                           rstN,
	input  logic                                           inValid,	// one vector this cycle
	input  fpRoundPkg::fpWide  [fpRoundPkg::laneCount-1:0] inData,
	input  fpRoundPkg::roundMode                           inMode,
	input  logic                                           modeWrite,	// load modeValue
	input  fpRoundPkg::roundMode                           modeValue,
	output logic                                           reqValid,
	output fpRoundPkg::laneReq [fpRoundPkg::laneCount-1:0] reqs
);

	fpRoundPkg::roundMode dynMode;	// dynamic mode register
	fpRoundPkg::roundMode effMode;	// mode the vector will carry

	// ========================================================================
	// mode resolution
	// ========================================================================
	// the register is read before this edge's write lands, so a vector that
	// shares a cycle with modeWrite still sees the previous mode
	always_comb begin
		if (inMode == fpRoundPkg::rmDynamic)
			effMode = dynMode;
		else
			effMode = inMode;		// static modes and reserved codes pass straight
	end

	// control state
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			reqValid <= 1'b0;
			dynMode  <= fpRoundPkg::rmNearestEven;	// default IEEE mode
		end else begin
			reqValid <= inValid;	// one-cycle strobe, one cycle later
			if (modeWrite)
				dynMode <= modeValue;
		end
	end

	// ========================================================================
	// request registers
	// ========================================================================
	// payload only moves on a valid vector, otherwise it holds
	always_ff @(posedge clk) begin
		if (inValid) begin
			for (int i = 0; i < fpRoundPkg::laneCount; i++) begin
				reqs[i].value <= inData[i];
				reqs[i].mode  <= effMode;	// same mode for every lane
			end
		end
	end

endmodule

// File: source/fpRoundLane.sv
module fpRoundLane (
	input  logic               clk,
	input  logic               rstN,
	input  logic               reqValid,	// req holds a new value
	input  fpRoundPkg::laneReq req,
	output logic               resValid,
	output fpRoundPkg::laneRes res
);

	// ========================================================================
	// field split
	// ========================================================================
	logic                                       sign;
	logic [fpRoundPkg::expWidth-1:0]            expIn;
	logic [fpRoundPkg::fracWidth:0]             sig;		// 24 bits, leading bit visible
	logic                                       lsb;		// least significant kept bit
	logic                                       rBit;
	logic                                       sBit;
	logic                                       expMax;		// inf or NaN on input
	logic                                       denorm;		// zero exponent
	logic                                       roundUp;
	logic [fpRoundPkg::expWidth+fpRoundPkg::fracWidth:0] rounded;	// {exp, sig} + roundUp
	logic [fpRoundPkg::expWidth-1:0]            expOut;
	logic                                       expOutMax;
	logic [fpRoundPkg::fracWidth-1:0]           frac;
	fpRoundPkg::laneRes                         resNext;

	assign sign   = req.value[fpRoundPkg::wideWidth-1];
	assign expIn  = req.value[fpRoundPkg::wideWidth-2 -: fpRoundPkg::expWidth];
	assign sig    = req.value[fpRoundPkg::fracWidth+2:2];
	assign lsb    = req.value[2];
	assign rBit   = req.value[1];
	assign sBit   = req.value[0];
	assign expMax = &expIn;
	assign denorm = ~|expIn;

	// ========================================================================
	// round-up decision
	// ========================================================================
	always_comb begin
		case (req.mode)
			fpRoundPkg::rmNearestEven: roundUp = rBit & (lsb | sBit);	// tie goes to even lsb
			fpRoundPkg::rmZero:        roundUp = 1'b0;
			fpRoundPkg::rmPlusInf:     roundUp = (rBit | sBit) & ~sign;
			fpRoundPkg::rmMinusInf:    roundUp = (rBit | sBit) & sign;
			fpRoundPkg::rmAway:        roundUp = rBit | sBit;
			default:                   roundUp = 1'b0;		// codes 5, 6: leave as is
		endcase
		// infinities and NaNs are never rounded
		if (expMax)
			roundUp = 1'b0;
	end

	// one adder for both fields, a carry out of the significand lands in the
	// exponent, so the largest finite value can only step up to infinity
	assign rounded   = {expIn, sig} + {{(fpRoundPkg::expWidth+fpRoundPkg::fracWidth){1'b0}}, roundUp};
	assign expOut    = rounded[fpRoundPkg::expWidth+fpRoundPkg::fracWidth -: fpRoundPkg::expWidth];
	assign expOutMax = &expOut;

	// ========================================================================
	// fraction select
	// ========================================================================
	always_comb begin
		if (roundUp && expOutMax)
			frac = '0;					// became infinity
		else if (roundUp && denorm)
			frac = rounded[fpRoundPkg::fracWidth:1];	// denormal, keep msb
		else if (roundUp)
			frac = rounded[fpRoundPkg::fracWidth-1:0];	// normal, hide msb
		else if (denorm)
			frac = sig[fpRoundPkg::fracWidth:1];		// denormal keeps leading bit
		else
			frac = sig[fpRoundPkg::fracWidth-1:0];		// normal or special, drop hidden bit
	end

	always_comb begin
		resNext.result   = {sign, expOut, frac};
		resNext.inexact  = ~expMax & (rBit | sBit);
		resNext.overflow = ~expMax & expOutMax;	// only a round-up can reach all ones here
	end

	// ========================================================================
	// result register
	// ========================================================================
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			resValid <= 1'b0;
		else
			resValid <= reqValid;
	end

	always_ff @(posedge clk) begin
		if (reqValid)
			res <= resNext;		// payload, held between vectors
	end

endmodule

// File: source/fpRoundFlags.sv
module fpRoundFlags (
	input  logic                                           clk,
	input  logic                                           rstN,
	input  logic                                           resValid,	// from lane zero
	input  logic                                           flagClear,	// drop sticky flags
	input  fpRoundPkg::laneRes [fpRoundPkg::laneCount-1:0] results,
	output logic                                           outValid,
	output fpRoundPkg::fpWord  [fpRoundPkg::laneCount-1:0] outData,
	output fpRoundPkg::fpFlags                             flags
);

	fpRoundPkg::fpFlags laneFlags;	// OR over the lanes of this vector
	fpRoundPkg::fpFlags flagsNext;

	// ========================================================================
	// output vector
	// ========================================================================
	// straight from the lane registers, no extra cycle
	assign outValid = resValid;

	always_comb begin
		for (int i = 0; i < fpRoundPkg::laneCount; i++)
			outData[i] = results[i].result;
	end

	// ========================================================================
	// sticky exception flags
	// ========================================================================
	always_comb begin
		laneFlags = '0;
		for (int i = 0; i < fpRoundPkg::laneCount; i++) begin
			laneFlags.inexact  = laneFlags.inexact | results[i].inexact;
			laneFlags.overflow = laneFlags.overflow | results[i].overflow;
		end
	end

	// clear wins over the old value, never over flags arriving the same cycle
	always_comb begin
		flagsNext = flagClear ? '0 : flags;
		if (outValid) begin
			flagsNext.inexact  = flagsNext.inexact | laneFlags.inexact;
			flagsNext.overflow = flagsNext.overflow | laneFlags.overflow;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			flags <= '0;
		else
			flags <= flagsNext;
	end

endmodule

// File: source/fpRoundArray.sv
module fpRoundArray (
	input  logic                                           clk,
	input  logic                                           rstN,
	input  logic                                           inValid,
	input  fpRoundPkg::fpWide  [fpRoundPkg::laneCount-1:0] inData,
	input  fpRoundPkg::roundMode                           inMode,
	input  logic                                           modeWrite,
	input  fpRoundPkg::roundMode                           modeValue,
	input  logic                                           flagClear,
	output logic                                           outValid,	// two clocks after inValid
	output fpRoundPkg::fpWord  [fpRoundPkg::laneCount-1:0] outData,
	output fpRoundPkg::fpFlags                             flags
);

	logic                                           reqValid;
	fpRoundPkg::laneReq [fpRoundPkg::laneCount-1:0] reqs;
	logic               [fpRoundPkg::laneCount-1:0] laneValid;	// identical timing on every lane
	fpRoundPkg::laneRes [fpRoundPkg::laneCount-1:0] results;

	// ========================================================================
	// stage 1: input register and mode resolution
	// ========================================================================
	fpRoundIssue issue (
		.clk       (clk),
		.rstN      (rstN),
		.inValid   (inValid),
		.inData    (inData),
		.inMode    (inMode),
		.modeWrite (modeWrite),
		.modeValue (modeValue),
		.reqValid  (reqValid),
		.reqs      (reqs)
	);

	// stage 2: one rounder per lane
	for (genvar lane = 0; lane < fpRoundPkg::laneCount; lane++) begin : gLane
		fpRoundLane rounder (
			.clk      (clk),
			.rstN     (rstN),
			.reqValid (reqValid),
			.req      (reqs[lane]),
			.resValid (laneValid[lane]),
			.res      (results[lane])
		);
	end

	// output mux and sticky flags, lane zero stands for all
	fpRoundFlags collect (
		.clk       (clk),
		.rstN      (rstN),
		.resValid  (laneValid[0]),
		.flagClear (flagClear),
		.results   (results),
		.outValid  (outValid),
		.outData   (outData),
		.flags     (flags)
	);

endmodule

// File: sim/fpRoundArrayTb.sv
module fpRoundArrayTb;
	timeunit 1ns;
	timeprecision 1ps;

	logic                                           clk;
	logic                                           rstN;
	logic                                           inValid;
	fpRoundPkg::fpWide  [fpRoundPkg::laneCount-1:0] inData;
	fpRoundPkg::roundMode                           inMode;
	logic                                           modeWrite;
	fpRoundPkg::roundMode                           modeValue;
	logic                                           flagClear;
	logic                                           outValid;
	fpRoundPkg::fpWord  [fpRoundPkg::laneCount-1:0] outData;
	fpRoundPkg::fpFlags                             flags;

	int                   errors = 0;
	int                   checks = 0;
	int                   tick = 0;		// falling edges seen so far
	logic [31:0]          lfsr = 32'hf9af_e005;
	fpRoundPkg::roundMode dynModel;		// what the mode register should hold
	fpRoundPkg::fpFlags   expFlags;		// sticky flags the DUT should show

	fpRoundArray DUT (
		.clk(clk), .rstN(rstN), .inValid(inValid), .inData(inData), .inMode(inMode),
		.modeWrite(modeWrite), .modeValue(modeValue), .flagClear(flagClear),
		.outValid(outValid), .outData(outData), .flags(flags)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;		// 40 ns period
	end

	always @(negedge clk) tick <= tick + 1;

	// ========================================================================
	// stimulus and reference model
	// ========================================================================
	// galois lfsr, one step per bit taken
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic fpRoundPkg::fpWide mk(input logic s, input logic [7:0] e,
			input logic [23:0] m, input logic [1:0] rs);
		return {s, e, m, rs};		// rs is {round, sticky}
	endfunction

	// expected word and flags, straight from the rounding rules
	function automatic fpRoundPkg::laneRes refRound(input fpRoundPkg::fpWide v,
			input fpRoundPkg::roundMode mode);
		logic               s, r, st, special, up;
		logic [7:0]         e, eNew;
		logic [23:0]        m;
		logic [24:0]        mSum;		// significand plus increment, with carry
		fpRoundPkg::laneRes res;
		s = v[34];
		e = v[33:26];
		m = v[25:2];
		r = v[1];
		st = v[0];
		special = (e == 8'hff);
		case (mode)
			fpRoundPkg::rmNearestEven: up = r & (m[0] | st);
			fpRoundPkg::rmPlusInf:     up = (r | st) & ~s;
			fpRoundPkg::rmMinusInf:    up = (r | st) & s;
			fpRoundPkg::rmAway:        up = r | st;
			default:                   up = 1'b0;		// rmZero and codes 5, 6
		endcase
		if (special)
			up = 1'b0;
		mSum = {1'b0, m} + {24'd0, up};
		eNew = e + {7'd0, mSum[24]};
		res.inexact  = ~special & (r | st);
		res.overflow = ~special & (eNew == 8'hff);
		if (special)
			res.result = {s, e, m[22:0]};		// inf / NaN unchanged
		else if (res.overflow)
			res.result = {s, 8'hff, 23'd0};
		else if (e == 8'd0)
			res.result = {s, eNew, mSum[23:1]};	// denormal keeps its leading bit
		else if (mSum[24])
			res.result = {s, eNew, 23'd0};
		else
			res.result = {s, eNew, mSum[22:0]};
		return res;
	endfunction

	// ========================================================================
	// checking helpers
	// ========================================================================
	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, got, want);
		end
	endtask

	// counts clocks from the edge after the issue edge
	task automatic waitOut(output int cycles, output bit ok);
		cycles = 0;
		ok = 1'b0;
		while (!ok && cycles < 16) begin
			@(negedge clk);
			cycles++;
			if (outValid)
				ok = 1'b1;
		end
		if (!ok) begin
			errors++;
			$display("timeout at %0t: outValid never rose within %0d clocks", $time, cycles);
		end
	endtask

	task automatic collectOut(input fpRoundPkg::fpWide [3:0] vals, input fpRoundPkg::roundMode used);
		int                 lat;
		bit                 ok;
		fpRoundPkg::laneRes want;
		waitOut(lat, ok);
		if (ok) begin
			compare("latency", 64'(lat), 64'd2);
			for (int i = 0; i < fpRoundPkg::laneCount; i++) begin
				want = refRound(vals[i], used);
				compare($sformatf("outData[%0d]", i), 64'(outData[i]), 64'(want.result));
				expFlags.inexact  = expFlags.inexact | want.inexact;
				expFlags.overflow = expFlags.overflow | want.overflow;
			end
		end
	endtask

	task automatic roundOne(input fpRoundPkg::fpWide [3:0] vals, input fpRoundPkg::roundMode sent,
			input fpRoundPkg::roundMode used);
		@(posedge clk);
		inValid <= 1'b1;
		inData  <= vals;
		inMode  <= sent;
		@(posedge clk);
		inValid <= 1'b0;
		collectOut(vals, used);
	endtask

	task automatic writeMode(input fpRoundPkg::roundMode m);
		@(posedge clk);
		modeWrite <= 1'b1;
		modeValue <= m;
		@(posedge clk);
		modeWrite <= 1'b0;
		dynModel = m;
	endtask

	task automatic clearFlags();
		@(posedge clk);
		flagClear <= 1'b1;
		@(posedge clk);
		flagClear <= 1'b0;
		expFlags = '0;
	endtask

	// flags land one edge after the output vector
	task automatic checkFlags();
		@(posedge clk);
		@(negedge clk);
		compare("flags", 64'(flags), 64'(expFlags));
	endtask

	// ========================================================================
	// directed tests
	// ========================================================================
	task automatic testTruncation();
		fpRoundPkg::fpWide [3:0] vals;
		vals[0] = mk(1'b0, 8'h80, 24'hC00001, 2'b00);
		vals[1] = mk(1'b1, 8'h7f, 24'hFFFFFF, 2'b01);
		vals[2] = mk(1'b0, 8'h01, 24'h800003, 2'b10);
		vals[3] = mk(1'b1, 8'h00, 24'h7FFFFF, 2'b11);	// denormal
		roundOne(vals, fpRoundPkg::rmZero, fpRoundPkg::rmZero);
	endtask

	task automatic testNearestEven();
		fpRoundPkg::fpWide [3:0] vals;
		vals[0] = mk(1'b0, 8'h80, 24'h800000, 2'b10);	// tie, even lsb stays
		vals[1] = mk(1'b1, 8'h80, 24'h800001, 2'b10);	// tie, odd lsb goes up
		vals[2] = mk(1'b0, 8'h80, 24'h800000, 2'b11);	// above half
		vals[3] = mk(1'b0, 8'h80, 24'hFFFFFF, 2'b10);	// carry into exponent
		roundOne(vals, fpRoundPkg::rmNearestEven, fpRoundPkg::rmNearestEven);
	endtask

	task automatic testDirected();
		fpRoundPkg::fpWide [3:0] vals;
		vals[0] = mk(1'b0, 8'h90, 24'hA00001, 2'b10);
		vals[1] = mk(1'b1, 8'h90, 24'hA00000, 2'b01);
		vals[2] = mk(1'b0, 8'h90, 24'hA00002, 2'b00);	// exact
		vals[3] = mk(1'b1, 8'h90, 24'hA00003, 2'b11);
		for (int m = 2; m <= 6; m++)		// +inf, -inf, away, then the two reserved codes
			roundOne(vals, 3'(m), 3'(m));
	endtask

	task automatic testDynamic();
		fpRoundPkg::fpWide [3:0] vals;
		vals[0] = mk(1'b0, 8'h70, 24'hB00001, 2'b10);
		vals[1] = mk(1'b1, 8'h70, 24'hB00000, 2'b10);
		vals[2] = mk(1'b0, 8'h70, 24'hB00000, 2'b01);
		vals[3] = mk(1'b1, 8'h70, 24'hB00001, 2'b11);
		for (int m = 0; m <= 4; m++) begin
			writeMode(3'(m));
			roundOne(vals, fpRoundPkg::rmDynamic, 3'(m));
			roundOne(vals, 3'(m), 3'(m));	// same mode given directly
		end
		// write together with a vector, the vector keeps the old mode
		writeMode(fpRoundPkg::rmZero);
		@(posedge clk);
		inValid   <= 1'b1;
		inData    <= vals;
		inMode    <= fpRoundPkg::rmDynamic;
		modeWrite <= 1'b1;
		modeValue <= fpRoundPkg::rmAway;
		@(posedge clk);
		inValid   <= 1'b0;
		modeWrite <= 1'b0;
		dynModel = fpRoundPkg::rmAway;
		collectOut(vals, fpRoundPkg::rmZero);
		roundOne(vals, fpRoundPkg::rmDynamic, fpRoundPkg::rmAway);
	endtask

	task automatic testFlags();
		fpRoundPkg::fpWide [3:0] vals;
		clearFlags();
		checkFlags();
		vals[0] = mk(1'b0, 8'h40, 24'h900000, 2'b00);	// exact
		vals[1] = mk(1'b0, 8'hff, 24'h800000, 2'b11);	// +inf
		vals[2] = mk(1'b1, 8'hff, 24'hC00001, 2'b11);	// NaN
		vals[3] = mk(1'b1, 8'hff, 24'h800000, 2'b01);	// -inf
		roundOne(vals, fpRoundPkg::rmNearestEven, fpRoundPkg::rmNearestEven);
		checkFlags();		// specials raise nothing
		vals[0] = mk(1'b0, 8'hfe, 24'hFFFFFF, 2'b10);	// largest finite, goes to inf
		roundOne(vals, fpRoundPkg::rmNearestEven, fpRoundPkg::rmNearestEven);
		checkFlags();
		vals[0] = mk(1'b0, 8'h40, 24'h900000, 2'b00);	// exact, no new flag
		roundOne(vals, fpRoundPkg::rmPlusInf, fpRoundPkg::rmPlusInf);
		checkFlags();		// still sticky
		// clear in the same cycle as an inexact vector
		vals[0] = mk(1'b0, 8'h40, 24'h900000, 2'b01);
		@(posedge clk);
		inValid <= 1'b1;
		inData  <= vals;
		inMode  <= fpRoundPkg::rmZero;
		@(posedge clk);
		inValid <= 1'b0;
		expFlags = '0;
		fork
			collectOut(vals, fpRoundPkg::rmZero);
			begin
				@(posedge clk);
				flagClear <= 1'b1;
				@(posedge clk);
				flagClear <= 1'b0;
			end
		join
		checkFlags();
	endtask

	task automatic testStreaming();
		fpRoundPkg::fpWide [3:0]                        vals;
		fpRoundPkg::roundMode                           mode;
		fpRoundPkg::roundMode                           used;
		logic [31:0]                                    hi;
		logic [31:0]                                    lo;
		fpRoundPkg::laneRes                             want;
		fpRoundPkg::fpWord [fpRoundPkg::laneCount-1:0]  words;
		fpRoundPkg::fpWord [fpRoundPkg::laneCount-1:0]  expWords [$];
		fpRoundPkg::fpWord [fpRoundPkg::laneCount-1:0]  w;
		int                                             issued [$];
		int                                             got;
		int                                             idle;
		clearFlags();
		fork
			begin
				for (int n = 0; n < 100; n++) begin
					for (int i = 0; i < fpRoundPkg::laneCount; i++) begin
						hi = takeBits(3);
						lo = takeBits(32);
						vals[i] = {hi[2:0], lo};
					end
					hi = takeBits(3);
					mode = hi[2:0];
					used = (mode == fpRoundPkg::rmDynamic) ? dynModel : mode;
					for (int i = 0; i < fpRoundPkg::laneCount; i++) begin
						want = refRound(vals[i], used);
						words[i] = want.result;
						expFlags.inexact  = expFlags.inexact | want.inexact;
						expFlags.overflow = expFlags.overflow | want.overflow;
					end
					@(posedge clk);
					inValid <= 1'b1;
					inData  <= vals;
					inMode  <= mode;
					expWords.push_back(words);
					issued.push_back(tick);
				end
				@(posedge clk);
				inValid <= 1'b0;
			end
			begin
				got = 0;
				idle = 0;
				while (got < 100 && idle < 8) begin
					@(negedge clk);
					if (!outValid) begin
						idle++;
					end else if (expWords.size() == 0) begin
						errors++;
						$display("outValid rose at %0t with no vector outstanding", $time);
						got++;
					end else begin
						idle = 0;
						w = expWords.pop_front();
						compare("stream latency", 64'(tick - issued.pop_front()), 64'd2);
						for (int i = 0; i < fpRoundPkg::laneCount; i++)
							compare($sformatf("outData[%0d]", i), 64'(outData[i]), 64'(w[i]));
						got++;
					end
				end
				if (got != 100) begin
					errors++;
					$display("timeout: only %0d of 100 streamed vectors came out", got);
				end
			end
		join
		checkFlags();
	endtask

	// ========================================================================
	// main sequence
	// ========================================================================
	initial begin
		rstN      = 1'b0;
		inValid   = 1'b0;
		inData    = '0;
		inMode    = fpRoundPkg::rmNearestEven;
		modeWrite = 1'b0;
		modeValue = fpRoundPkg::rmNearestEven;
		flagClear = 1'b0;
		dynModel  = fpRoundPkg::rmNearestEven;	// reset value of the register
		expFlags  = '0;
		repeat (8) @(posedge clk);
		rstN <= 1'b1;
		testTruncation();
		testNearestEven();
		testDirected();
		testDynamic();
		testFlags();
		testStreaming();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: src.f
source/fpRoundPkg.sv
source/fpRoundIssue.sv
source/fpRoundLane.sv
source/fpRoundFlags.sv
source/fpRoundArray.sv
sim/fpRoundArrayTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the rounding array testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module fpRoundArrayTb -Mdir obj_dir -o simv
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

output=$(./obj_dir/simv)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the result is decided by the testbench's own closing message
if printf '%s\n' "$output" | grep -qx "ALL TESTS PASSED"; then
	echo "run passed"
	exit 0
else
	echo "run failed"
	exit 1
fi
